// ==== source/mcu_cmd_pkg.sv ====
package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // spi byte counter, 1 = command byte
  localparam int BYTE_CNT_W = 8;

  // snes command buffer holds 512 entries
  localparam int SNESCMD_ADDR_W = 9;

  // memory address and mask width unless the top level overrides it
  localparam int DEF_ADDR_W = 24;

  typedef logic [7:0] byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // command encodings
  ////////////////////////////////////////////////////////////////////////////

  // command group, high nibble of the command byte
  typedef enum logic [3:0] {
    OP_SET_ADDR     = 4'h0,
    OP_ROM_MASK     = 4'h1,
    OP_SRAM_MASK    = 4'h2,
    OP_MAPPER       = 4'h3,
    OP_MEM_READ     = 4'h8,
    OP_MEM_WRITE    = 4'h9,
    OP_SNESCMD_READ = 4'hA,
    OP_SNESCMD      = 4'hD,
    OP_SYSTEM       = 4'hE,
    OP_QUERY        = 4'hF
  } mcu_op_e;

  // commands decoded on the whole byte
  typedef enum logic [7:0] {
    CMD_SNESCMD_ADDR  = 8'hD0,
    CMD_SNESCMD_RDINC = 8'hD1,
    CMD_SNESCMD_WR    = 8'hD2,
    CMD_FEATURES      = 8'hED,
    CMD_REGION        = 8'hEE,
    CMD_ECHO_ID       = 8'hF0,
    CMD_LOOPBACK      = 8'hFF
  } mcu_subop_e;

  ////////////////////////////////////////////////////////////////////////////
  // reply values
  ////////////////////////////////////////////////////////////////////////////

  // identification byte, lets the mcu check the link
  localparam byte_t REPLY_ID = 8'hA5;

endpackage

// ==== source/spi_cmd_if.sv ====
`timescale 1ns/1ps

interface spi_cmd_if;
  import mcu_cmd_pkg::*;

  // one-cycle strobes, one per received byte
  logic                  cmd_ready;
  logic                  param_ready;

  // command byte stays valid for the whole transaction
  byte_t                 cmd_data;
  byte_t                 param_data;

  // 1 at the command byte, 2 at the first parameter
  logic [BYTE_CNT_W-1:0] byte_cnt;

  modport sink (
    input cmd_ready,
    input param_ready,
    input cmd_data,
    input param_data,
    input byte_cnt
  );

endinterface

// ==== source/cfg_regs.sv ====
`timescale 1ns/1ps

module cfg_regs #(
  parameter int ADDR_W = mcu_cmd_pkg::DEF_ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,
  spi_cmd_if.sink           bus,
  output logic [3:0]        mapper,
  output logic [ADDR_W-1:0] rom_mask,
  output logic [ADDR_W-1:0] sram_mask,
  output logic [15:0]       features,
  output logic              region
);
  import mcu_cmd_pkg::*;

  localparam int MASK_BYTES = ADDR_W / 8;

  mcu_op_e               op;
  mcu_subop_e            subop;
  logic [BYTE_CNT_W-1:0] slot;
  byte_t                 feat_stage;

  assign op    = mcu_op_e'(bus.cmd_data[7:4]);
  assign subop = mcu_subop_e'(bus.cmd_data);

  // index of the parameter byte, 0 for byte_cnt 2
  assign slot = bus.byte_cnt - BYTE_CNT_W'(2);

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mapper    <= '0;
      rom_mask  <= '0;
      sram_mask <= '0;
      features  <= '0;
      region    <= 1'b0;
    end else if (bus.cmd_ready) begin
      // mapper number rides in the command byte itself
      if (op == OP_MAPPER) begin
        mapper <= bus.cmd_data[3:0];
      end
    end else if (bus.param_ready) begin
      case (op)
        OP_ROM_MASK: begin
          // high byte first
          if (slot < MASK_BYTES) begin
            rom_mask[(MASK_BYTES-1-slot)*8 +: 8] <= bus.param_data;
          end
        end
        OP_SRAM_MASK: begin
          if (slot < MASK_BYTES) begin
            sram_mask[(MASK_BYTES-1-slot)*8 +: 8] <= bus.param_data;
          end
        end
        OP_SYSTEM: begin
          // all 16 feature bits switch together on the second byte
          if (subop == CMD_FEATURES && bus.byte_cnt == BYTE_CNT_W'(3)) begin
            features <= {feat_stage, bus.param_data};
          end
          if (subop == CMD_REGION) begin
            region <= bus.param_data[0];
          end
        end
        default: ;
      endcase
    end
  end

  // high feature byte waits here for its partner
  always_ff @(posedge clk) begin
    if (bus.param_ready && subop == CMD_FEATURES && bus.byte_cnt == BYTE_CNT_W'(2)) begin
      feat_stage <= bus.param_data;
    end
  end

endmodule

// ==== source/mem_access.sv ====
`timescale 1ns/1ps

module mem_access #(
  parameter int ADDR_W = mcu_cmd_pkg::DEF_ADDR_W
) (
  input  logic               clk,
  input  logic               rst_n,
  spi_cmd_if.sink            bus,
  input  logic               rq_rdy,
  output logic [ADDR_W-1:0]  addr,
  output logic               rrq,
  output logic               wrq,
  output mcu_cmd_pkg::byte_t wr_data,
  output logic               next_addr
);
  import mcu_cmd_pkg::*;

  localparam int ADDR_BYTES = ADDR_W / 8;

  mcu_op_e               op;
  logic [BYTE_CNT_W-1:0] slot;
  logic [1:0]            rdy_hist;
  logic                  mem_cmd;
  logic                  addr_step;

  assign op   = mcu_op_e'(bus.cmd_data[7:4]);
  assign slot = bus.byte_cnt - BYTE_CNT_W'(2);

  ////////////////////////////////////////////////////////////////////////////
  // arbiter completion
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_hist <= '0;
    end else begin
      rdy_hist <= {rdy_hist[0], rq_rdy};
    end
  end

  // one pulse per rising edge of rq_rdy
  assign next_addr = rdy_hist[0] & ~rdy_hist[1];

  // byte_cnt >= 1 + bit 4 is the same as byte_cnt > bit 4
  assign mem_cmd   = (op == OP_MEM_READ) || (op == OP_MEM_WRITE);
  assign addr_step = next_addr && mem_cmd && bus.cmd_data[3]
                     && (bus.byte_cnt > BYTE_CNT_W'(bus.cmd_data[4]));

  ////////////////////////////////////////////////////////////////////////////
  // address register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (bus.param_ready && op == OP_SET_ADDR) begin
      if (slot == '0) begin
        // top byte first, the lower bytes start from zero
        addr <= {bus.param_data, {(ADDR_W-8){1'b0}}};
      end else if (slot < ADDR_BYTES) begin
        addr[(ADDR_BYTES-1-slot)*8 +: 8] <= bus.param_data;
      end
    end else if (addr_step) begin
      addr <= addr + 1'b1;
    end
  end

  // request pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rrq <= 1'b0;
      wrq <= 1'b0;
    end else begin
      rrq <= (bus.cmd_ready || bus.param_ready) && op == OP_MEM_READ;
      wrq <= bus.param_ready && op == OP_MEM_WRITE;
    end
  end

  // write data for the arbiter
  always_ff @(posedge clk) begin
    if (bus.param_ready && op == OP_MEM_WRITE) begin
      wr_data <= bus.param_data;
    end
  end

endmodule

// ==== source/snescmd_port.sv ====
`timescale 1ns/1ps

module snescmd_port (
  input  logic                                   clk,
  input  logic                                   rst_n,
  spi_cmd_if.sink                                bus,
  output logic [mcu_cmd_pkg::SNESCMD_ADDR_W-1:0] addr,
  output mcu_cmd_pkg::byte_t                     wr_data,
  output logic                                   we
);
  import mcu_cmd_pkg::*;

  mcu_op_e    op;
  mcu_subop_e subop;
  logic       snes_param;

  assign op         = mcu_op_e'(bus.cmd_data[7:4]);
  assign subop      = mcu_subop_e'(bus.cmd_data);
  assign snes_param = bus.param_ready && op == OP_SNESCMD;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
      we   <= 1'b0;
    end else begin
      we <= 1'b0;
      if (snes_param) begin
        case (subop)
          CMD_SNESCMD_ADDR: begin
            // low byte, then bit 8
            if (bus.byte_cnt == BYTE_CNT_W'(2)) begin
              addr[7:0] <= bus.param_data;
            end else if (bus.byte_cnt == BYTE_CNT_W'(3)) begin
              addr[8] <= bus.param_data[0];
            end
          end
          CMD_SNESCMD_RDINC: addr <= addr + 1'b1;
          CMD_SNESCMD_WR: begin
            // one write, then the third byte only moves on
            if (bus.byte_cnt == BYTE_CNT_W'(2)) begin
              we <= 1'b1;
            end else if (bus.byte_cnt == BYTE_CNT_W'(3)) begin
              addr <= addr + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (snes_param && subop == CMD_SNESCMD_WR) begin
      wr_data <= bus.param_data;
    end
  end

endmodule

// ==== source/reply_reg.sv ====
`timescale 1ns/1ps

module reply_reg (
  input  logic               clk,
  input  logic               rst_n,
  spi_cmd_if.sink            bus,
  input  logic               next_addr,
  input  mcu_cmd_pkg::byte_t mem_rdata,
  input  mcu_cmd_pkg::byte_t snescmd_rdata,
  output mcu_cmd_pkg::byte_t reply
);
  import mcu_cmd_pkg::*;

  mcu_op_e    op;
  mcu_subop_e subop;
  logic       strobe;
  logic       snes_rd;

  assign op     = mcu_op_e'(bus.cmd_data[7:4]);
  assign subop  = mcu_subop_e'(bus.cmd_data);
  assign strobe = bus.cmd_ready || bus.param_ready;

  // D1 reads the entry before its address steps
  assign snes_rd = (op == OP_SNESCMD_READ) || (subop == CMD_SNESCMD_RDINC);

  ////////////////////////////////////////////////////////////////////////////
  // reply byte shifted out on the next spi transfer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply <= '0;
    end else if (op == OP_MEM_READ && next_addr) begin
      // memory data arrives when the arbiter is done
      reply <= mem_rdata;
    end else if (strobe) begin
      if (snes_rd) begin
        reply <= snescmd_rdata;
      end else if (op == OP_QUERY) begin
        case (subop)
          CMD_ECHO_ID: reply <= REPLY_ID;
          CMD_LOOPBACK: begin
            if (bus.param_ready) begin
              reply <= bus.param_data;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== source/mcu_cmd.sv ====
`timescale 1ns/1ps

module mcu_cmd #(
  parameter int ADDR_W = mcu_cmd_pkg::DEF_ADDR_W
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // spi byte stream
  input  logic                                   cmd_ready,
  input  logic                                   param_ready,
  input  mcu_cmd_pkg::byte_t                     cmd_data,
  input  mcu_cmd_pkg::byte_t                     param_data,
  input  logic [mcu_cmd_pkg::BYTE_CNT_W-1:0]     spi_byte_cnt,
  output mcu_cmd_pkg::byte_t                     spi_data_out,
  // configuration
  output logic [3:0]                             mcu_mapper,
  output logic [ADDR_W-1:0]                      rom_mask_out,
  output logic [ADDR_W-1:0]                      saveram_mask_out,
  output logic [15:0]                            featurebits_out,
  output logic                                   region_out,
  // memory arbiter
  output logic [ADDR_W-1:0]                      addr_out,
  output logic                                   mcu_rrq,
  output logic                                   mcu_wrq,
  input  logic                                   mcu_rq_rdy,
  output mcu_cmd_pkg::byte_t                     mcu_data_out,
  input  mcu_cmd_pkg::byte_t                     mcu_data_in,
  // snes command buffer
  input  mcu_cmd_pkg::byte_t                     snescmd_data_in,
  output mcu_cmd_pkg::byte_t                     snescmd_data_out,
  output logic [mcu_cmd_pkg::SNESCMD_ADDR_W-1:0] snescmd_addr_out,
  output logic                                   snescmd_we_out
);

  logic next_addr;

  spi_cmd_if bus ();

  assign bus.cmd_ready   = cmd_ready;
  assign bus.param_ready = param_ready;
  assign bus.cmd_data    = cmd_data;
  assign bus.param_data  = param_data;
  assign bus.byte_cnt    = spi_byte_cnt;

  cfg_regs #(.ADDR_W(ADDR_W)) u_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus.sink),
    .mapper    (mcu_mapper),
    .rom_mask  (rom_mask_out),
    .sram_mask (saveram_mask_out),
    .features  (featurebits_out),
    .region    (region_out)
  );

  mem_access #(.ADDR_W(ADDR_W)) u_mem_access (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus.sink),
    .rq_rdy    (mcu_rq_rdy),
    .addr      (addr_out),
    .rrq       (mcu_rrq),
    .wrq       (mcu_wrq),
    .wr_data   (mcu_data_out),
    .next_addr (next_addr)
  );

  snescmd_port u_snescmd_port (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus.sink),
    .addr    (snescmd_addr_out),
    .wr_data (snescmd_data_out),
    .we      (snescmd_we_out)
  );

  reply_reg u_reply_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (bus.sink),
    .next_addr     (next_addr),
    .mem_rdata     (mcu_data_in),
    .snescmd_rdata (snescmd_data_in),
    .reply         (spi_data_out)
  );

endmodule

// ==== tests/tb_mcu_cmd_tasks.svh ====
// command byte, the byte count restarts at 1
task automatic send_cmd(input byte_t cmd);
  repeat (IDLE_CYCLES) @(negedge clk);
  cmd_data     = cmd;
  spi_byte_cnt = BYTE_CNT_W'(1);
  cmd_ready    = 1'b1;
  @(negedge clk);
  cmd_ready    = 1'b0;
endtask

// next parameter byte of the current command
task automatic send_param(input byte_t data);
  repeat (IDLE_CYCLES) @(negedge clk);
  param_data   = data;
  spi_byte_cnt = spi_byte_cnt + 1'b1;
  param_ready  = 1'b1;
  @(negedge clk);
  param_ready  = 1'b0;
endtask

// address or mask value, high byte first
task automatic send_word(input byte_t cmd, input logic [ADDR_W-1:0] value);
  int i;
  send_cmd(cmd);
  for (i = ADDR_W / 8 - 1; i >= 0; i--) begin
    send_param(value[i*8 +: 8]);
  end
endtask

// arbiter answer, then next_addr and the reply update
task automatic wait_mem_done();
  int unsigned n;
  n = 0;
  while (rdy_seen == rdy_taken && n < 20) begin
    @(negedge clk);
    n++;
  end
  if (rdy_seen == rdy_taken) begin
    err_cnt++;
    $display("memory model saw no request within 20 cycles");
  end
  rdy_taken = rdy_seen;
  repeat (2) @(negedge clk);
endtask

// ==== tests/tb_mcu_cmd.sv ====
`timescale 1ns/1ps

module tb_mcu_cmd;
  import mcu_cmd_pkg::*;

  localparam int ADDR_W      = DEF_ADDR_W;
  localparam int IDLE_CYCLES = 2;
  localparam int MAX_CYCLES  = 2000;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic cmd_ready = 1'b0;
  logic param_ready = 1'b0;
  byte_t cmd_data = '0;
  byte_t param_data = '0;
  logic [BYTE_CNT_W-1:0] spi_byte_cnt = '0;
  logic mcu_rq_rdy = 1'b0;
  byte_t mcu_data_in = '0;
  byte_t snescmd_data_in = '0;

  byte_t spi_data_out, mcu_data_out, snescmd_data_out;
  logic [3:0] mcu_mapper;
  logic [ADDR_W-1:0] rom_mask_out, saveram_mask_out, addr_out;
  logic [15:0] featurebits_out;
  logic region_out, mcu_rrq, mcu_wrq, snescmd_we_out;
  logic [SNESCMD_ADDR_W-1:0] snescmd_addr_out;

  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned rdy_wait = 0;
  int unsigned rdy_seen = 0;
  int unsigned rdy_taken = 0;
  int unsigned we_cnt = 0;
  byte_t snes_buf [0:511];
  logic exp_rrq, exp_wrq, exp_we;
  byte_t exp_wdata;

  mcu_cmd #(.ADDR_W(ADDR_W)) u_dut (.*);

  always #20 clk = ~clk;

  `include "tb_mcu_cmd_tasks.svh"

  // arbiter data depends on every address bit
  function automatic byte_t mem_data(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ a[15:8] ^ {a[19:16], a[23:20]} ^ 8'h96;
  endfunction

  function automatic byte_t buf_fill(input logic [SNESCMD_ADDR_W-1:0] a);
    return a[7:0] ^ {a[8], 7'h35};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp)
      else begin
        err_cnt++;
        $display("Error: %s = %h, expected %h", name, got, exp);
      end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // arbiter and command buffer models
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    mcu_rq_rdy = 1'b0;
    if (rdy_wait != 0) begin
      rdy_wait--;
      if (rdy_wait == 0) begin
        mcu_rq_rdy = 1'b1;
        rdy_seen++;
      end
    end
    // random latency of 1 to 4 cycles
    if (mcu_rrq || mcu_wrq) rdy_wait = 1 + ($urandom() % 4);
    mcu_data_in = mem_data(addr_out);
  end

  always @(negedge clk) begin
    if (snescmd_we_out) begin
      snes_buf[snescmd_addr_out] = snescmd_data_out;
      we_cnt++;
    end
    snescmd_data_in = snes_buf[snescmd_addr_out];
  end

  // pulses expected one cycle after each strobe
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_rrq   <= 1'b0;
      exp_wrq   <= 1'b0;
      exp_we    <= 1'b0;
      exp_wdata <= '0;
    end else begin
      exp_rrq <= (cmd_ready || param_ready) && cmd_data[7:4] == 4'h8;
      exp_wrq <= param_ready && cmd_data[7:4] == 4'h9;
      exp_we  <= param_ready && cmd_data == 8'hD2 && spi_byte_cnt == 8'd2;
      if (param_ready && cmd_data[7:4] == 4'h9) exp_wdata <= param_data;
    end
  end

  read_request_pulse: assert property (@(negedge clk) disable iff (!rst_n) mcu_rrq == exp_rrq)
    else begin
      err_cnt++;
      $display("Error: mcu_rrq = %h, expected %h", mcu_rrq, exp_rrq);
    end
  write_request_pulse: assert property (@(negedge clk) disable iff (!rst_n) mcu_wrq == exp_wrq)
    else begin
      err_cnt++;
      $display("Error: mcu_wrq = %h, expected %h", mcu_wrq, exp_wrq);
    end
  write_data_match: assert property (@(negedge clk) disable iff (!rst_n)
    !mcu_wrq || mcu_data_out == exp_wdata)
    else begin
      err_cnt++;
      $display("Error: mcu_data_out = %h, expected %h", mcu_data_out, exp_wdata);
    end
  buffer_write_pulse: assert property (@(negedge clk) disable iff (!rst_n)
    snescmd_we_out == exp_we)
    else begin
      err_cnt++;
      $display("Error: snescmd_we_out = %h, expected %h", snescmd_we_out, exp_we);
    end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, the run did not end within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [ADDR_W-1:0] rnd, exp_addr;
    logic [SNESCMD_ADDR_W-1:0] snes_addr, snes_next;
    byte_t b0, b1;
    int i;
    void'($urandom(32'h16725460));
    for (i = 0; i < 512; i++) snes_buf[i] = buf_fill(SNESCMD_ADDR_W'(i));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("mcu_rrq", mcu_rrq, 0);
    check_value("mcu_wrq", mcu_wrq, 0);
    check_value("snescmd_we_out", snescmd_we_out, 0);
    check_value("mcu_mapper", mcu_mapper, 0);
    check_value("rom_mask_out", rom_mask_out, 0);
    check_value("saveram_mask_out", saveram_mask_out, 0);
    check_value("featurebits_out", featurebits_out, 0);
    check_value("region_out", region_out, 0);
    check_value("addr_out", addr_out, 0);
    check_value("spi_data_out", spi_data_out, 0);

    // configuration registers
    b0 = byte_t'($urandom());
    send_cmd({4'h3, b0[3:0]});
    check_value("mcu_mapper", mcu_mapper, b0[3:0]);
    rnd = ADDR_W'($urandom());
    send_word(8'h10, rnd);
    check_value("rom_mask_out", rom_mask_out, rnd);
    rnd = ADDR_W'($urandom());
    send_word(8'h20, rnd);
    check_value("saveram_mask_out", saveram_mask_out, rnd);
    b0 = byte_t'($urandom());
    b1 = byte_t'($urandom());
    send_cmd(8'hED);
    send_param(b0);
    send_param(b1);
    check_value("featurebits_out", featurebits_out, {b0, b1});
    // region bit set so the flag leaves its reset value
    b0 = byte_t'($urandom()) | 8'h01;
    send_cmd(8'hEE);
    send_param(b0);
    check_value("region_out", region_out, b0[0]);

    // memory read with the address stepping after each access
    exp_addr = ADDR_W'($urandom());
    send_word(8'h00, exp_addr);
    check_value("addr_out", addr_out, exp_addr);
    send_cmd(8'h88);
    for (i = 0; i < 5; i++) begin
      if (i > 0) send_param(byte_t'($urandom()));
      wait_mem_done();
      check_value("spi_data_out", spi_data_out, mem_data(exp_addr));
      exp_addr = exp_addr + 1'b1;
    end
    check_value("addr_out", addr_out, exp_addr);

    // memory write
    send_cmd(8'h98);
    for (i = 0; i < 4; i++) begin
      send_param(byte_t'($urandom()));
      wait_mem_done();
      exp_addr = exp_addr + 1'b1;
    end
    check_value("addr_out", addr_out, exp_addr);

    // one snes command buffer write and its read back
    snes_addr = SNESCMD_ADDR_W'($urandom());
    snes_next = snes_addr + 1'b1;
    send_cmd(8'hD0);
    send_param(snes_addr[7:0]);
    send_param({7'd0, snes_addr[8]});
    check_value("snescmd_addr_out", snescmd_addr_out, snes_addr);
    b0 = byte_t'($urandom());
    send_cmd(8'hD2);
    send_param(b0);
    check_value("snescmd_addr_out", snescmd_addr_out, snes_addr);
    check_value("snescmd_data_out", snescmd_data_out, b0);
    send_param(8'h00);
    check_value("snescmd_addr_out", snescmd_addr_out, snes_next);
    check_value("snescmd_we_out count", we_cnt, 1);
    send_cmd(8'hD0);
    send_param(snes_addr[7:0]);
    send_param({7'd0, snes_addr[8]});
    send_cmd(8'hD1);
    check_value("spi_data_out", spi_data_out, b0);
    send_param(8'h00);
    check_value("spi_data_out", spi_data_out, b0);
    send_param(8'h00);
    check_value("spi_data_out", spi_data_out, buf_fill(snes_next));
    snes_next = snes_addr + 2'd2;
    check_value("snescmd_addr_out", snescmd_addr_out, snes_next);

    // link check and loopback
    send_cmd(8'hF0);
    check_value("spi_data_out", spi_data_out, 8'hA5);
    send_cmd(8'hFF);
    for (i = 0; i < 3; i++) begin
      b0 = byte_t'($urandom());
      send_param(b0);
      check_value("spi_data_out", spi_data_out, b0);
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tests
source/mcu_cmd_pkg.sv
source/spi_cmd_if.sv
source/cfg_regs.sv
source/mem_access.sv
source/snescmd_port.sv
source/reply_reg.sv
source/mcu_cmd.sv
tests/tb_mcu_cmd.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := compile.f
TOP        := tb_mcu_cmd
RTL_TOP    := mcu_cmd
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
